//--- tetris_pkg.sv
package tetris_pkg;

    // Playfield size, row 0 is the top row
    localparam int board_rows = 20;
    localparam int board_cols = 10;

    // One bit per cell, set when occupied
    typedef logic [board_rows-1:0][board_cols-1:0] board_t;

    typedef enum logic [2:0] {
        piece_i,
        piece_o,
        piece_t,
        piece_s,
        piece_z,
        piece_j,
        piece_l
    } piece_kind_t;

    // 4x4 box, bit r*4+c holds box row r and box column c
    typedef logic [15:0] shape_t;

    // Lock request, col and row locate box cell (0,0) on the board
    typedef struct packed {
        piece_kind_t kind;
        logic [1:0]  rot;
        logic [3:0]  col;
        logic [4:0]  row;
    } lock_cmd_t;

    // Merged board handed from the lock stage to the clear stage
    typedef struct packed {
        board_t board;
        logic   overlap;
    } merge_t;

    typedef struct packed {
        logic [2:0] lines;
        logic [7:0] score;
        logic       game_over;
    } result_t;

endpackage

//--- piece_shapes.sv
module piece_shapes import tetris_pkg::*; (
    input  piece_kind_t kind,
    input  logic [1:0]  rot,
    output shape_t      shape
);

    // Masks are written as hex, one nibble per box row with row 0 in the low nibble.
    // Rotations step clockwise inside the fixed 4x4 box
    always_comb begin
        case ({kind, rot})
            // I piece
            {piece_i, 2'd0}: shape = 16'h00F0;
            {piece_i, 2'd1}: shape = 16'h4444;
            {piece_i, 2'd2}: shape = 16'h0F00;
            {piece_i, 2'd3}: shape = 16'h2222;

            // O piece does not change with rotation
            {piece_o, 2'd0}: shape = 16'h0066;
            {piece_o, 2'd1}: shape = 16'h0066;
            {piece_o, 2'd2}: shape = 16'h0066;
            {piece_o, 2'd3}: shape = 16'h0066;

            // T piece
            {piece_t, 2'd0}: shape = 16'h0072;
            {piece_t, 2'd1}: shape = 16'h0262;
            {piece_t, 2'd2}: shape = 16'h0270;
            {piece_t, 2'd3}: shape = 16'h0232;

            // S piece
            {piece_s, 2'd0}: shape = 16'h0036;
            {piece_s, 2'd1}: shape = 16'h0462;
            {piece_s, 2'd2}: shape = 16'h0360;
            {piece_s, 2'd3}: shape = 16'h0231;

            // Z piece
            {piece_z, 2'd0}: shape = 16'h0063;
            {piece_z, 2'd1}: shape = 16'h0264;
            {piece_z, 2'd2}: shape = 16'h0630;
            {piece_z, 2'd3}: shape = 16'h0132;

            // J piece
            {piece_j, 2'd0}: shape = 16'h0071;
            {piece_j, 2'd1}: shape = 16'h0226;
            {piece_j, 2'd2}: shape = 16'h0470;
            {piece_j, 2'd3}: shape = 16'h0322;

            // L piece
            {piece_l, 2'd0}: shape = 16'h0074;
            {piece_l, 2'd1}: shape = 16'h0622;
            {piece_l, 2'd2}: shape = 16'h0170;
            {piece_l, 2'd3}: shape = 16'h0223;

            // Unused kind code places nothing
            default:         shape = 16'h0000;
        endcase
    end

endmodule

//--- piece_lock.sv
module piece_lock import tetris_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      lock_req,
    input  lock_cmd_t lock_cmd,
    input  board_t    board,
    input  logic      board_ready,
    input  logic      merge_ack,
    output logic      lock_ack,
    output logic      merge_req,
    output merge_t    merge
);

    lock_cmd_t cmd_q;
    logic      cmd_valid;
    shape_t    shape;
    board_t    placed;
    logic      hit;
    merge_t    merge_next;

    piece_shapes u_piece_shapes (
        .kind  (cmd_q.kind),
        .rot   (cmd_q.rot),
        .shape (shape)
    );

    // Place the mask on the board and look for cells off the board or already taken
    always_comb begin
        int br;
        int bc;
        placed = '0;
        hit    = 1'b0;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                br = int'(cmd_q.row) + r;
                bc = int'(cmd_q.col) + c;
                if (shape[r*4+c]) begin
                    if (br >= board_rows || bc >= board_cols) begin
                        hit = 1'b1;
                    end else begin
                        if (board[br][bc])
                            hit = 1'b1;
                        placed[br][bc] = 1'b1;
                    end
                end
            end
        end
        // A blocked piece leaves the board untouched
        merge_next.board   = hit ? board : (board | placed);
        merge_next.overlap = hit;
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            cmd_valid <= 1'b0;
            lock_ack  <= 1'b0;
            merge_req <= 1'b0;
        end else begin
            // Lock side handshake, a new command only into an empty register
            if (lock_req && !lock_ack && !cmd_valid) begin
                cmd_valid <= 1'b1;
                lock_ack  <= 1'b1;
            end else if (lock_ack && !lock_req) begin
                lock_ack <= 1'b0;
            end

            // Merge only against a settled board
            if (cmd_valid && !merge_req && board_ready) begin
                cmd_valid <= 1'b0;
                merge_req <= 1'b1;
            end else if (merge_req && merge_ack) begin
                merge_req <= 1'b0;
            end
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (lock_req && !lock_ack && !cmd_valid)
            cmd_q <= lock_cmd;
        if (cmd_valid && !merge_req && board_ready)
            merge <= merge_next;
    end

endmodule

//--- line_clear.sv
module line_clear import tetris_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    merge_req,
    input  merge_t  merge,
    input  logic    result_ack,
    output logic    merge_ack,
    output board_t  board,
    output logic    board_ready,
    output logic    result_req,
    output result_t result
);

    typedef enum logic [1:0] {
        ph_idle,
        ph_scan,
        ph_report
    } phase_t;

    phase_t     phase;
    logic [4:0] eval_row;
    logic [2:0] lines;
    logic [7:0] score;
    logic       game_over;
    logic       row_full;
    board_t     shifted;

    // Settled only with every handshake closed and no scan running
    assign board_ready = (phase == ph_idle) && !merge_req && !merge_ack &&
                         !result_req && !result_ack;

    assign result.lines     = lines;
    assign result.score     = score;
    assign result.game_over = game_over;

    assign row_full = &board[eval_row];

    // Drop every row at or above eval_row by one, the top row comes in empty
    always_comb begin
        shifted    = board;
        shifted[0] = '0;
        for (int k = 1; k < board_rows; k++) begin
            if (k <= eval_row)
                shifted[k] = board[k-1];
        end
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            phase      <= ph_idle;
            merge_ack  <= 1'b0;
            result_req <= 1'b0;
            board      <= '0;
            eval_row   <= 5'd19;
            lines      <= 3'd0;
            score      <= 8'd0;
            game_over  <= 1'b0;
        end else begin
            if (merge_ack && !merge_req)
                merge_ack <= 1'b0;

            case (phase)
                ph_idle: begin
                    if (merge_req && !merge_ack) begin
                        merge_ack <= 1'b1;
                        board     <= merge.board;
                        game_over <= merge.overlap;
                        lines     <= 3'd0;
                        eval_row  <= 5'd19;
                        // Blocked lock has nothing to clear
                        phase     <= merge.overlap ? ph_report : ph_scan;
                    end
                end

                ph_scan: begin
                    if (row_full) begin
                        // Stay on this row, the row moved into it may be full too
                        board <= shifted;
                        lines <= lines + 3'd1;
                        if (score != 8'd255)
                            score <= score + 8'd1;
                    end else if (eval_row == 5'd0) begin
                        phase <= ph_report;
                    end else begin
                        eval_row <= eval_row - 5'd1;
                    end
                end

                ph_report: begin
                    if (!result_req) begin
                        result_req <= 1'b1;
                    end else if (result_ack) begin
                        result_req <= 1'b0;
                        phase      <= ph_idle;
                    end
                end

                default: phase <= ph_idle;
            endcase
        end
    end

endmodule

//--- tetris_top.sv
module tetris_top import tetris_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      lock_req,
    input  lock_cmd_t lock_cmd,
    input  logic      result_ack,
    output logic      lock_ack,
    output logic      result_req,
    output result_t   result,
    output board_t    board
);

    logic   merge_req;
    logic   merge_ack;
    merge_t merge;
    logic   board_ready;

    piece_lock u_piece_lock (
        .clk         (clk),
        .reset       (reset),
        .lock_req    (lock_req),
        .lock_cmd    (lock_cmd),
        .board       (board),
        .board_ready (board_ready),
        .merge_ack   (merge_ack),
        .lock_ack    (lock_ack),
        .merge_req   (merge_req),
        .merge       (merge)
    );

    line_clear u_line_clear (
        .clk         (clk),
        .reset       (reset),
        .merge_req   (merge_req),
        .merge       (merge),
        .result_ack  (result_ack),
        .merge_ack   (merge_ack),
        .board       (board),
        .board_ready (board_ready),
        .result_req  (result_req),
        .result      (result)
    );

endmodule

//--- tetris_chk.sv
module tetris_chk import tetris_pkg::*; (
    input logic    clk,
    input logic    reset,
    input logic    lock_req,
    input logic    lock_ack,
    input logic    merge_req,
    input logic    merge_ack,
    input logic    result_req,
    input logic    result_ack,
    input result_t result,
    input board_t  board
);

    int         fail_count = 0;
    logic [7:0] prev_score;
    board_t     prev_board;

    function automatic logic [7:0] add_sat(input logic [7:0] base, input logic [2:0] inc);
        logic [8:0] sum;
        sum = base + inc;
        return sum[8] ? 8'd255 : sum[7:0];
    endfunction

    // Score and board as left by the last completed result handshake
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            prev_score <= 8'd0;
            prev_board <= '0;
        end else if (result_req && result_ack) begin
            prev_score <= result.score;
            prev_board <= board;
        end
    end

    // Four-phase rules, a req waits for its ack and an ack waits for its req to fall
    lock_req_held: assert property (@(posedge clk) disable iff (reset)
        lock_req && !lock_ack |=> lock_req)
        else begin $error("lock_req fell before lock_ack"); fail_count++; end
    lock_ack_held: assert property (@(posedge clk) disable iff (reset)
        lock_ack && lock_req |=> lock_ack)
        else begin $error("lock_ack fell while lock_req high"); fail_count++; end
    merge_req_held: assert property (@(posedge clk) disable iff (reset)
        merge_req && !merge_ack |=> merge_req)
        else begin $error("merge_req fell before merge_ack"); fail_count++; end
    merge_ack_held: assert property (@(posedge clk) disable iff (reset)
        merge_ack && merge_req |=> merge_ack)
        else begin $error("merge_ack fell while merge_req high"); fail_count++; end
    result_req_held: assert property (@(posedge clk) disable iff (reset)
        result_req && !result_ack |=> result_req)
        else begin $error("result_req fell before result_ack"); fail_count++; end
    result_ack_held: assert property (@(posedge clk) disable iff (reset)
        result_ack && result_req |=> result_ack)
        else begin $error("result_ack fell while result_req high"); fail_count++; end

    score_step: assert property (@(posedge clk) disable iff (reset)
        result_req |-> result.score == add_sat(prev_score, result.lines))
        else begin $error("score does not follow lines cleared"); fail_count++; end

    // A blocked lock must not touch the board
    over_keeps_board: assert property (@(posedge clk) disable iff (reset)
        $rose(result_req) && result.game_over |-> board == prev_board)
        else begin $error("board changed on game over"); fail_count++; end

    bottom_not_full: assert property (@(posedge clk) disable iff (reset)
        result_req |-> !(&board[board_rows-1]))
        else begin $error("full bottom row left after scan"); fail_count++; end

endmodule

bind tetris_top tetris_chk u_tetris_chk (
    .clk        (clk),
    .reset      (reset),
    .lock_req   (lock_req),
    .lock_ack   (lock_ack),
    .merge_req  (merge_req),
    .merge_ack  (merge_ack),
    .result_req (result_req),
    .result_ack (result_ack),
    .result     (result),
    .board      (board)
);

//--- tetris_tb.sv
module tetris_tb import tetris_pkg::*; ();

    localparam int lock_limit   = 50;
    localparam int result_limit = 200;

    logic        clk = 1'b0;
    logic        reset;
    logic        lock_req;
    lock_cmd_t   lock_cmd;
    logic        result_ack;
    logic        lock_ack;
    logic        result_req;
    result_t     result;
    board_t      board;
    logic [15:0] lfsr_state = 16'd33;
    board_t      exp_board;
    string       test_name;
    int          errors = 0;
    int          errors_at_start;
    int          chk_at_start;
    int          tests_run = 0;
    int          tests_failed = 0;
    event        abort_run;

    always #5 clk = ~clk;

    tetris_top u_tetris_top (
        .clk        (clk),
        .reset      (reset),
        .lock_req   (lock_req),
        .lock_cmd   (lock_cmd),
        .result_ack (result_ack),
        .lock_ack   (lock_ack),
        .result_req (result_req),
        .result     (result),
        .board      (board)
    );

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | lfsr_state[0];
        end
    endtask

    function automatic logic [9:0] cols(input int lo, input int hi);
        logic [9:0] m;
        m = '0;
        for (int c = lo; c <= hi; c++)
            m[c] = 1'b1;
        return m;
    endfunction

    task automatic give_up(input string what);
        $display("error in test %s: %s", test_name, what);
        errors++;
        -> abort_run;
        @(posedge clk);
    endtask

    task automatic expect_equal(input string what, input logic [199:0] exp,
                                input logic [199:0] act);
        assert (act === exp) else begin
            $display("mismatch %s %s: expected %0h actual %0h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset      <= 1'b1;
        lock_req   <= 1'b0;
        result_ack <= 1'b0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        exp_board = '0;
    endtask

    task automatic do_lock(input piece_kind_t kind, input int rot, input int col,
                           input int row, output int ack_cycles);
        int cnt;
        @(posedge clk);
        lock_cmd <= '{kind, 2'(rot), 4'(col), 5'(row)};
        lock_req <= 1'b1;
        cnt = 0;
        do begin
            @(posedge clk);
            cnt++;
        end while (!lock_ack && cnt < lock_limit);
        if (!lock_ack)
            give_up("lock_ack never rose");
        ack_cycles = cnt;
        lock_req <= 1'b0;
        cnt = 0;
        do begin
            @(posedge clk);
            cnt++;
        end while (lock_ack && cnt < lock_limit);
        if (lock_ack)
            give_up("lock_ack stayed high after lock_req fell");
    endtask

    task automatic get_result(input int exp_lines, input int exp_score, input logic exp_over);
        int cnt;
        int delay;
        cnt = 0;
        do begin
            @(posedge clk);
            cnt++;
        end while (!result_req && cnt < result_limit);
        if (!result_req)
            give_up("result_req never rose");
        expect_equal("lines", exp_lines, result.lines);
        expect_equal("score", exp_score, result.score);
        expect_equal("game_over", exp_over, result.game_over);
        expect_equal("board", exp_board, board);
        // Late ack of 0 to 7 cycles
        random_bits(3, delay);
        repeat (delay) @(posedge clk);
        result_ack <= 1'b1;
        cnt = 0;
        do begin
            @(posedge clk);
            cnt++;
        end while (result_req && cnt < result_limit);
        if (result_req)
            give_up("result_req stayed high after result_ack");
        result_ack <= 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = errors;
        chk_at_start    = u_tetris_top.u_tetris_chk.fail_count;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == errors_at_start &&
            u_tetris_top.u_tetris_chk.fail_count == chk_at_start) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: failed", test_name);
        end
    endtask

    task automatic run_tests();
        int n;
        start_test("single_lock");
        apply_reset();
        // Box row 1 lands on row 20 below the board
        do_lock(piece_o, 0, 3, 19, n);
        get_result(0, 0, 1'b1);
        do_lock(piece_o, 0, 3, 18, n);
        exp_board[18] = cols(4, 5);
        exp_board[19] = cols(4, 5);
        get_result(0, 0, 1'b0);
        end_test();

        start_test("line_clear");
        apply_reset();
        do_lock(piece_i, 0, 0, 18, n);
        exp_board[19] = cols(0, 3);
        get_result(0, 0, 1'b0);
        do_lock(piece_i, 0, 4, 18, n);
        exp_board[19] = cols(0, 7);
        get_result(0, 0, 1'b0);
        do_lock(piece_o, 0, 7, 18, n);
        exp_board     = '0;
        exp_board[19] = cols(8, 9);
        get_result(1, 1, 1'b0);
        end_test();

        start_test("cascade");
        apply_reset();
        do_lock(piece_i, 0, 0, 17, n);
        exp_board[18] = cols(0, 3);
        get_result(0, 0, 1'b0);
        do_lock(piece_i, 0, 4, 17, n);
        exp_board[18] = cols(0, 7);
        get_result(0, 0, 1'b0);
        do_lock(piece_i, 0, 0, 18, n);
        exp_board[19] = cols(0, 3);
        get_result(0, 0, 1'b0);
        do_lock(piece_i, 0, 4, 18, n);
        exp_board[19] = cols(0, 7);
        get_result(0, 0, 1'b0);
        // Marker above the two rows that will clear
        do_lock(piece_o, 0, 0, 16, n);
        exp_board[16] = cols(1, 2);
        exp_board[17] = cols(1, 2);
        get_result(0, 0, 1'b0);
        do_lock(piece_o, 0, 7, 18, n);
        exp_board     = '0;
        exp_board[18] = cols(1, 2);
        exp_board[19] = cols(1, 2);
        get_result(2, 2, 1'b0);
        end_test();

        start_test("overlap");
        do_lock(piece_o, 0, 0, 18, n);
        get_result(0, 2, 1'b1);
        end_test();

        start_test("two_in_flight");
        do_lock(piece_i, 0, 3, 18, n);
        do_lock(piece_i, 0, 3, 17, n);
        expect_equal("second lock_ack cycles", 2, n);
        exp_board[19] = cols(1, 6);
        get_result(0, 2, 1'b0);
        exp_board[18] = cols(1, 6);
        get_result(0, 2, 1'b0);
        end_test();
    endtask

    initial begin
        int chk_errors;
        reset      = 1'b1;
        lock_req   = 1'b0;
        lock_cmd   = '0;
        result_ack = 1'b0;
        fork
            run_tests();
            @(abort_run);
        join_any
        disable fork;
        chk_errors = u_tetris_top.u_tetris_chk.fail_count;
        $display("tests run %0d, failed %0d, check errors %0d, assertion errors %0d",
                 tests_run, tests_failed, errors, chk_errors);
        if (errors == 0 && chk_errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

//--- vlog.f
tetris_pkg.sv
piece_shapes.sv
piece_lock.sv
line_clear.sv
tetris_top.sv
tetris_chk.sv
tetris_tb.sv
